// ==== hdl/biriq_pkg.sv ====
// biriq execute stage
// shared widths, codes and types

package biriq_pkg;

  localparam int XLEN    = 32;
  localparam int SHAMT_W = 5;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [2:0]         funct3_t;
  typedef logic [6:0]         funct7_t;
  typedef logic [4:0]         shift_op_t;

  // shifter op codes
  // bit 0 picks right, bit 1 rotate, bit 2 sign fill, bit 3 single-bit ops
  localparam shift_op_t SH_SLL  = 5'b00000;
  localparam shift_op_t SH_SRL  = 5'b00001;
  localparam shift_op_t SH_ROL  = 5'b00010;
  localparam shift_op_t SH_ROR  = 5'b00011;
  localparam shift_op_t SH_SRA  = 5'b00101;
  localparam shift_op_t SH_BCLR = 5'b01000;
  localparam shift_op_t SH_BEXT = 5'b01011;
  localparam shift_op_t SH_BINV = 5'b11000;
  localparam shift_op_t SH_BSET = 5'b11010;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // funct3 groups of the OP and OP-IMM opcodes
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct7 codes
  localparam funct7_t F7_BASE      = 7'b0000000;
  localparam funct7_t F7_ALT       = 7'b0100000; // sub, sra
  localparam funct7_t F7_ROT       = 7'b0110000; // rol, ror
  localparam funct7_t F7_BCLR_BEXT = 7'b0100100;
  localparam funct7_t F7_BINV      = 7'b0110100;
  localparam funct7_t F7_BSET      = 7'b0010100;

endpackage

// ==== hdl/biriq_exec_if.sv ====
// decoded operands and unit controls

`timescale 1ns/100ps

interface biriq_exec_if import biriq_pkg::*; ();

  xlen_t     op_a;      // rs1
  xlen_t     op_b;      // rs2 or immediate
  alu_op_e   alu_op;
  shift_op_t shift_op;
  logic      use_shift; // result comes from the shifter

  modport dec (
    output op_a,
    output op_b,
    output alu_op,
    output shift_op,
    output use_shift
  );

  modport alu (
    input op_a,
    input op_b,
    input alu_op
  );

  modport shf (
    input op_a,
    input op_b,
    input shift_op
  );

endinterface

// ==== hdl/biriq_decoder.sv ====
// execute stage decoder

`timescale 1ns/100ps

module biriq_decoder import biriq_pkg::*; #(
  parameter bit C_HAS_ZBB_EXTENSION = 1'b0,
  parameter bit C_HAS_ZBS_EXTENSION = 1'b0
) (
  input  funct3_t     funct3_i,
  input  funct7_t     funct7_i,
  input  logic        use_imm_i,
  input  xlen_t       rs1_i,
  input  xlen_t       rs2_i,
  input  xlen_t       imm_i,
  biriq_exec_if.dec   ex,
  output logic        illegal_o
);

  logic f7_ok; // funct7 check for the plain alu groups

  assign ex.op_a = rs1_i;
  assign ex.op_b = use_imm_i ? imm_i : rs2_i;

  // with an immediate the funct7 bits belong to the immediate
  assign f7_ok = use_imm_i || (funct7_i == F7_BASE);

  always_comb begin
    ex.alu_op    = ALU_ADD;
    ex.shift_op  = SH_SLL;
    ex.use_shift = 1'b0;
    illegal_o    = 1'b0;

    case (funct3_i)
      F3_ADD_SUB: begin
        if (funct7_i == F7_BASE) begin
          ex.alu_op = ALU_ADD;
        end else if (funct7_i == F7_ALT && !use_imm_i) begin
          ex.alu_op = ALU_SUB;
        end else begin
          illegal_o = 1'b1; // no subi
        end
      end
      F3_SLL: begin
        ex.use_shift = 1'b1;
        case (funct7_i)
          F7_BASE: ex.shift_op = SH_SLL;
          F7_ROT: begin
            ex.shift_op = SH_ROL;
            illegal_o   = use_imm_i || !C_HAS_ZBB_EXTENSION; // no roli
          end
          F7_BCLR_BEXT: begin
            ex.shift_op = SH_BCLR;
            illegal_o   = !C_HAS_ZBS_EXTENSION;
          end
          F7_BINV: begin
            ex.shift_op = SH_BINV;
            illegal_o   = !C_HAS_ZBS_EXTENSION;
          end
          F7_BSET: begin
            ex.shift_op = SH_BSET;
            illegal_o   = !C_HAS_ZBS_EXTENSION;
          end
          default: illegal_o = 1'b1;
        endcase
      end
      F3_SRL_SRA: begin
        ex.use_shift = 1'b1;
        case (funct7_i)
          F7_BASE: ex.shift_op = SH_SRL;
          F7_ALT:  ex.shift_op = SH_SRA;
          F7_ROT: begin
            ex.shift_op = SH_ROR;
            illegal_o   = !C_HAS_ZBB_EXTENSION;
          end
          F7_BCLR_BEXT: begin
            ex.shift_op = SH_BEXT;
            illegal_o   = !C_HAS_ZBS_EXTENSION;
          end
          default: illegal_o = 1'b1;
        endcase
      end
      F3_SLT: begin
        ex.alu_op = ALU_SLT;
        illegal_o = !f7_ok;
      end
      F3_SLTU: begin
        ex.alu_op = ALU_SLTU;
        illegal_o = !f7_ok;
      end
      F3_XOR: begin
        ex.alu_op = ALU_XOR;
        illegal_o = !f7_ok;
      end
      F3_OR: begin
        ex.alu_op = ALU_OR;
        illegal_o = !f7_ok;
      end
      default: begin // F3_AND
        ex.alu_op = ALU_AND;
        illegal_o = !f7_ok;
      end
    endcase
  end

endmodule

// ==== hdl/biriq_alu.sv ====
// adder, compare and logic unit

`timescale 1ns/100ps

module biriq_alu import biriq_pkg::*; (
  biriq_exec_if.alu ex,
  output xlen_t     res_o
);

  logic            sub_en;
  xlen_t           b_add;   // op_b, inverted for subtraction
  logic [XLEN:0]   sum;     // carry out in the top bit
  logic            lt_s;
  logic            lt_u;

  // compares reuse the subtractor
  assign sub_en = (ex.alu_op == ALU_SUB) || (ex.alu_op == ALU_SLT) ||
                  (ex.alu_op == ALU_SLTU);

  assign b_add = sub_en ? ~ex.op_b : ex.op_b;
  assign sum   = {1'b0, ex.op_a} + {1'b0, b_add} + {{XLEN{1'b0}}, sub_en};

  // no carry out of a - b means a borrow, so a < b unsigned
  assign lt_u = ~sum[XLEN];

  // differing signs decide directly, else the sign of the difference
  assign lt_s = (ex.op_a[XLEN-1] != ex.op_b[XLEN-1]) ? ex.op_a[XLEN-1]
                                                     : sum[XLEN-1];

  always_comb begin
    case (ex.alu_op)
      ALU_ADD,
      ALU_SUB:  res_o = sum[XLEN-1:0];
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  res_o = ex.op_a ^ ex.op_b;
      ALU_OR:   res_o = ex.op_a | ex.op_b;
      ALU_AND:  res_o = ex.op_a & ex.op_b;
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== hdl/biriq_shifter.sv ====
// barrel shifter with rotate and single-bit ops

`timescale 1ns/100ps

module biriq_shifter import biriq_pkg::*; #(
  parameter bit C_HAS_ZBB_EXTENSION = 1'b0,
  parameter bit C_HAS_ZBS_EXTENSION = 1'b0
) (
  biriq_exec_if.shf ex,
  output xlen_t     res_o
);

  function automatic xlen_t bit_rev(input xlen_t v);
    xlen_t r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  shamt_t shamt;
  logic   dir_right;  // op bit 0, left ops run through bit reversal
  logic   rot_en;
  logic   sign_fill;
  logic   single_bit; // zbs group
  xlen_t  operand;
  xlen_t  stage [SHAMT_W+1];
  xlen_t  shift_res;
  xlen_t  postgate_res;

  assign shamt      = ex.op_b[SHAMT_W-1:0];
  assign dir_right  = ex.shift_op[0];
  assign single_bit = C_HAS_ZBS_EXTENSION && ex.shift_op[3];

  // rotate feeds the dropped bits back in at the top
  assign rot_en = C_HAS_ZBB_EXTENSION && ex.shift_op[1] && !ex.shift_op[3];

  // only sra has bit 2 set outside the zbs group
  assign sign_fill = !ex.shift_op[3] && ex.shift_op[2] && ex.op_a[XLEN-1];

  // bclr, binv, bset move a single one into place; bext shifts rs1 down
  assign operand = (single_bit && !dir_right) ? xlen_t'(1) : ex.op_a;

  assign stage[0] = dir_right ? operand : bit_rev(operand);

  // log2 right shifter, stage s moves by 2**s
  for (genvar s = 0; s < SHAMT_W; s++) begin : g_stage
    localparam int W = 1 << s;
    logic [W-1:0] fill;
    xlen_t        shifted;

    assign fill      = rot_en ? stage[s][W-1:0] : {W{sign_fill}};
    assign shifted   = {fill, stage[s][XLEN-1:W]};
    assign stage[s+1] = shamt[s] ? shifted : stage[s];
  end

  assign shift_res = dir_right ? stage[SHAMT_W] : bit_rev(stage[SHAMT_W]);

  // combine the shifted mask with rs1
  always_comb begin
    case ({ex.shift_op[4], ex.shift_op[1]})
      2'b00:   postgate_res = ex.op_a & ~shift_res;               // bclr
      2'b01:   postgate_res = {{(XLEN-1){1'b0}}, shift_res[0]};   // bext
      2'b10:   postgate_res = ex.op_a ^ shift_res;                // binv
      default: postgate_res = ex.op_a | shift_res;                // bset
    endcase
  end

  assign res_o = single_bit ? postgate_res : shift_res;

endmodule

// ==== hdl/biriq_execute.sv ====
// rv32 integer execute stage
// decode, alu, shifter and one output register

`timescale 1ns/100ps

module biriq_execute import biriq_pkg::*; #(
  parameter bit C_HAS_ZBB_EXTENSION = 1'b1,
  parameter bit C_HAS_ZBS_EXTENSION = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    valid_i,
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  input  logic    use_imm_i,
  input  xlen_t   rs1_i,
  input  xlen_t   rs2_i,
  input  xlen_t   imm_i,
  output xlen_t   result_o,
  output logic    valid_o,
  output logic    illegal_o
);

  logic  illegal;
  xlen_t alu_res;
  xlen_t shf_res;
  xlen_t res_sel;

  biriq_exec_if ex ();

  biriq_decoder #(
    .C_HAS_ZBB_EXTENSION (C_HAS_ZBB_EXTENSION),
    .C_HAS_ZBS_EXTENSION (C_HAS_ZBS_EXTENSION)
  ) i_decoder (
    .funct3_i  (funct3_i),
    .funct7_i  (funct7_i),
    .use_imm_i (use_imm_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .imm_i     (imm_i),
    .ex        (ex.dec),
    .illegal_o (illegal)
  );

  biriq_alu i_alu (
    .ex    (ex.alu),
    .res_o (alu_res)
  );

  biriq_shifter #(
    .C_HAS_ZBB_EXTENSION (C_HAS_ZBB_EXTENSION),
    .C_HAS_ZBS_EXTENSION (C_HAS_ZBS_EXTENSION)
  ) i_shifter (
    .ex    (ex.shf),
    .res_o (shf_res)
  );

  // illegal ops leave a zero result
  assign res_sel = illegal       ? '0      :
                   ex.use_shift ? shf_res : alu_res;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o   <= 1'b0;
      illegal_o <= 1'b0;
      result_o  <= '0;
    end else begin
      valid_o   <= valid_i;
      illegal_o <= valid_i && illegal; // low on idle cycles
      if (valid_i) begin
        result_o <= res_sel; // held while idle
      end
    end
  end

endmodule

// ==== bench/biriq_execute_props.sv ====
// timing checks on the execute stage outputs

`timescale 1ns/100ps

module biriq_execute_props import biriq_pkg::*; (
  input logic  clk_i,
  input logic  rst_i,
  input logic  valid_i,
  input xlen_t result_o,
  input logic  valid_o,
  input logic  illegal_o
);

  int fail_cnt = 0;

  // one cycle latency, idle cycles included
  a_valid_follows: assert property (
    @(posedge clk_i) !rst_i |=> (valid_o == $past(valid_i))
  ) else begin
    $error("valid_o does not follow valid_i one cycle later");
    fail_cnt++;
  end

  a_illegal_zero: assert property (
    @(posedge clk_i) illegal_o |-> (result_o == '0)
  ) else begin
    $error("illegal_o is high with a nonzero result_o");
    fail_cnt++;
  end

  a_reset_idle: assert property (
    @(posedge clk_i) rst_i |=> !valid_o
  ) else begin
    $error("valid_o is high during reset");
    fail_cnt++;
  end

endmodule

// ==== bench/biriq_execute_tb.sv ====
// execute stage testbench

`timescale 1ns/100ps

module biriq_execute_tb import biriq_pkg::*;;

  localparam int    RESET_CYCLES = 10;
  localparam int    N_RAND       = 64;
  localparam int    MARGIN       = 20;
  localparam xlen_t PAT          = 32'h8765_4321; // shift test pattern

  typedef struct {
    string   name;
    logic    valid;
    funct3_t f3;
    funct7_t f7;
    logic    imm;
    xlen_t   a;
    xlen_t   b;     // rs2 or immediate, by imm
    logic    ill;
    xlen_t   res;
  } case_t;

  logic    clk_i;
  logic    rst_i;
  logic    valid_i;
  funct3_t funct3_i;
  funct7_t funct7_i;
  logic    use_imm_i;
  xlen_t   rs1_i;
  xlen_t   rs2_i;
  xlen_t   imm_i;
  xlen_t   result_o;
  logic    valid_o;
  logic    illegal_o;

  case_t       cases [$];
  logic [31:0] rng = 32'd71218;
  int          cycles = 0;
  int          limit = 0;
  int          n_tests = 0;
  int          n_fail = 0;

  // expectation for the op in flight
  string exp_name;
  logic  exp_valid;
  logic  exp_ill;
  xlen_t exp_res;
  xlen_t last_res;  // result_o holds this over idle cycles

  biriq_execute #(
    .C_HAS_ZBB_EXTENSION (1'b1),
    .C_HAS_ZBS_EXTENSION (1'b1)
  ) i_dut (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (valid_i),
    .funct3_i  (funct3_i),
    .funct7_i  (funct7_i),
    .use_imm_i (use_imm_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .imm_i     (imm_i),
    .result_o  (result_o),
    .valid_o   (valid_o),
    .illegal_o (illegal_o)
  );

  bind biriq_execute biriq_execute_props i_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (valid_i),
    .result_o  (result_o),
    .valid_o   (valid_o),
    .illegal_o (illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycles <= cycles + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // reference behavior, returns {illegal, result}
  function automatic logic [XLEN:0] model_op(input funct3_t f3, input funct7_t f7,
                                             input logic imm, input xlen_t a, input xlen_t b);
    logic  ill;
    xlen_t r;
    int    sh;
    ill = 1'b0;
    r   = '0;
    sh  = int'(b[SHAMT_W-1:0]);
    case (f3)
      3'b000: begin
        if (f7 == F7_BASE) r = a + b;
        else if (f7 == F7_ALT && !imm) r = a - b;
        else ill = 1'b1;
      end
      3'b001: begin
        if (f7 == F7_BASE) r = a << sh;
        else if (f7 == F7_ROT && !imm) r = (a << sh) | (a >> (XLEN - sh));
        else if (f7 == F7_BCLR_BEXT) r = a & ~(32'h1 << sh);
        else if (f7 == F7_BINV) r = a ^ (32'h1 << sh);
        else if (f7 == F7_BSET) r = a | (32'h1 << sh);
        else ill = 1'b1;
      end
      3'b101: begin
        if (f7 == F7_BASE) r = a >> sh;
        else if (f7 == F7_ALT) r = $signed(a) >>> sh;
        else if (f7 == F7_ROT) r = (a >> sh) | (a << (XLEN - sh));
        else if (f7 == F7_BCLR_BEXT) r = (a >> sh) & 32'h1;
        else ill = 1'b1;
      end
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
      3'b011:  r = (a < b) ? 32'h1 : 32'h0;
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    // funct7 only matters for the register form of the plain alu ops
    if (f3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111} && !imm && f7 != F7_BASE)
      ill = 1'b1;
    if (ill)
      r = '0;
    return {ill, r};
  endfunction

  // mostly legal funct7 codes, now and then a random one
  function automatic funct7_t pick_funct7(input logic [2:0] sel, input funct7_t raw);
    case (sel)
      3'd0:    return F7_BASE;
      3'd1:    return F7_ALT;
      3'd2:    return F7_ROT;
      3'd3:    return F7_BCLR_BEXT;
      3'd4:    return F7_BINV;
      3'd5:    return F7_BSET;
      default: return raw;
    endcase
  endfunction

  task automatic add_case(input string name, input logic v, input funct3_t f3,
                          input funct7_t f7, input logic imm, input xlen_t a, input xlen_t b,
                          input logic ill, input xlen_t res);
    cases.push_back('{name, v, f3, f7, imm, a, b, ill, res});
  endtask

  task automatic check_result();
    bit ok;
    ok = 1'b1;
    assert (valid_o === exp_valid) else begin
      $display("Error: time %0t, valid_o = %b, expected %b", $time, valid_o, exp_valid);
      ok = 1'b0;
    end
    assert (illegal_o === exp_ill) else begin
      $display("Error: time %0t, illegal_o = %b, expected %b", $time, illegal_o, exp_ill);
      ok = 1'b0;
    end
    assert (result_o === exp_res) else begin
      $display("Error: time %0t, result_o = %h, expected %h", $time, result_o, exp_res);
      ok = 1'b0;
    end
    n_tests++;
    if (!ok)
      n_fail++;
    $display("test %0d %s: %s", n_tests, exp_name, ok ? "ok" : "failed");
  endtask

  // one op per cycle, the previous one is checked just before driving the next
  task automatic apply_op(input string name, input logic v, input funct3_t f3,
                          input funct7_t f7, input logic imm, input xlen_t a, input xlen_t b,
                          input logic ill, input xlen_t res);
    @(posedge clk_i);
    #1;
    check_result();
    #1;
    valid_i   = v;
    funct3_i  = f3;
    funct7_i  = f7;
    use_imm_i = imm;
    rs1_i     = a;
    rs2_i     = imm ? ~b : b; // the unused source carries a different value
    imm_i     = imm ? b : ~b;
    exp_name    = name;
    exp_valid   = v;
    exp_ill     = v && ill;
    if (v)
      last_res = ill ? '0 : res;
    exp_res = last_res;
  endtask

  initial begin
    wait (limit > 0);
    wait (cycles >= limit);
    $display("timeout after %0d cycles, the test sequence did not finish", cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [XLEN:0] exp;
    logic [31:0]   ctl;
    xlen_t         a;
    xlen_t         b;
    funct7_t       f7;

    rst_i     = 1'b1;
    valid_i   = 1'b0;
    funct3_i  = '0;
    funct7_i  = '0;
    use_imm_i = 1'b0;
    rs1_i     = '0;
    rs2_i     = '0;
    imm_i     = '0;

    add_case("add",      1, 3'b000, F7_BASE, 0, 32'h0000_0005, 32'h0000_0003, 0, 32'h0000_0008);
    add_case("addi",     1, 3'b000, F7_BASE, 1, 32'h1000_0000, 32'hFFFF_FFFF, 0, 32'h0FFF_FFFF);
    add_case("sub",      1, 3'b000, F7_ALT,  0, 32'h0000_0003, 32'h0000_0005, 0, 32'hFFFF_FFFE);
    add_case("sub min",  1, 3'b000, F7_ALT,  0, 32'h8000_0000, 32'h0000_0001, 0, 32'h7FFF_FFFF);
    add_case("slt neg",  1, 3'b010, F7_BASE, 0, 32'hFFFF_FFFF, 32'h0000_0001, 0, 32'h0000_0001);
    add_case("slt max",  1, 3'b010, F7_BASE, 0, 32'h7FFF_FFFF, 32'h8000_0000, 0, 32'h0000_0000);
    add_case("slti",     1, 3'b010, 7'h55,   1, 32'h8000_0000, 32'h7FFF_FFFF, 0, 32'h0000_0001);
    add_case("sltu",     1, 3'b011, F7_BASE, 0, 32'hFFFF_FFFF, 32'h0000_0001, 0, 32'h0000_0000);
    add_case("sltiu",    1, 3'b011, F7_BASE, 1, 32'h0000_0000, 32'hFFFF_FFFF, 0, 32'h0000_0001);
    add_case("xor",      1, 3'b100, F7_BASE, 0, 32'hF0F0_F0F0, 32'hFF00_FF00, 0, 32'h0FF0_0FF0);
    add_case("xori",     1, 3'b100, F7_BASE, 1, 32'h1234_5678, 32'hFFFF_FFFF, 0, 32'hEDCB_A987);
    add_case("or",       1, 3'b110, F7_BASE, 0, 32'hF0F0_0000, 32'h0000_0F0F, 0, 32'hF0F0_0F0F);
    add_case("ori",      1, 3'b110, F7_BASE, 1, 32'h1234_0000, 32'h0000_5678, 0, 32'h1234_5678);
    add_case("and",      1, 3'b111, F7_BASE, 0, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 0, 32'h00F0_00F0);
    add_case("andi",     1, 3'b111, F7_BASE, 1, 32'hDEAD_BEEF, 32'h0000_FFFF, 0, 32'h0000_BEEF);
    add_case("idle",     0, 3'b000, F7_BASE, 0, 32'h0000_0001, 32'h0000_0001, 0, 32'h0000_0000);
    add_case("sll 0",    1, 3'b001, F7_BASE, 0, PAT, 32'h0000_0000, 0, PAT);
    add_case("sll 1",    1, 3'b001, F7_BASE, 0, PAT, 32'h0000_0001, 0, 32'h0ECA_8642);
    add_case("sll 16",   1, 3'b001, F7_BASE, 0, PAT, 32'h0000_0010, 0, 32'h4321_0000);
    add_case("slli 31",  1, 3'b001, F7_BASE, 1, PAT, 32'h0000_0FFF, 0, 32'h8000_0000);
    add_case("srl 1",    1, 3'b101, F7_BASE, 0, PAT, 32'h0000_0001, 0, 32'h43B2_A190);
    add_case("srl 16",   1, 3'b101, F7_BASE, 0, PAT, 32'hFFFF_FFF0, 0, 32'h0000_8765);
    add_case("srl 31",   1, 3'b101, F7_BASE, 0, PAT, 32'h0000_001F, 0, 32'h0000_0001);
    add_case("sra 1",    1, 3'b101, F7_ALT,  0, PAT, 32'h0000_0001, 0, 32'hC3B2_A190);
    add_case("srai 16",  1, 3'b101, F7_ALT,  1, PAT, 32'h0000_0010, 0, 32'hFFFF_8765);
    add_case("sra 31",   1, 3'b101, F7_ALT,  0, PAT, 32'h0000_001F, 0, 32'hFFFF_FFFF);
    add_case("rol 1",    1, 3'b001, F7_ROT,  0, PAT, 32'h0000_0001, 0, 32'h0ECA_8643);
    add_case("rol 16",   1, 3'b001, F7_ROT,  0, PAT, 32'h0000_0010, 0, 32'h4321_8765);
    add_case("ror 0",    1, 3'b101, F7_ROT,  0, PAT, 32'h0000_0000, 0, PAT);
    add_case("ror 1",    1, 3'b101, F7_ROT,  0, PAT, 32'h0000_0001, 0, 32'hC3B2_A190);
    add_case("rori 31",  1, 3'b101, F7_ROT,  1, PAT, 32'h0000_003F, 0, 32'h0ECA_8643);
    add_case("bclr",     1, 3'b001, F7_BCLR_BEXT, 0, '1, 32'h0000_0005, 0, 32'hFFFF_FFDF);
    add_case("bclri 31", 1, 3'b001, F7_BCLR_BEXT, 1, '1, 32'h0000_001F, 0, 32'h7FFF_FFFF);
    add_case("bset 0",   1, 3'b001, F7_BSET, 0, '0, 32'h0000_0000, 0, 32'h0000_0001);
    add_case("bset 31",  1, 3'b001, F7_BSET, 0, '0, 32'hFFFF_FFFF, 0, 32'h8000_0000);
    add_case("binv",     1, 3'b001, F7_BINV, 0, 32'hAAAA_AAAA, 32'h1, 0, 32'hAAAA_AAA8);
    add_case("binvi",    1, 3'b001, F7_BINV, 1, 32'h5555_5555, 32'h10, 0, 32'h5554_5555);
    add_case("bext",     1, 3'b101, F7_BCLR_BEXT, 0, 32'hAAAA_AAAA, 32'h01, 0, 32'h1);
    add_case("bexti",    1, 3'b101, F7_BCLR_BEXT, 1, 32'hAAAA_AAAA, 32'h1E, 0, 32'h0);
    add_case("bext 31",  1, 3'b101, F7_BCLR_BEXT, 0, '1, 32'hFFFF_FFFF, 0, 32'h1);
    add_case("subi",     1, 3'b000, F7_ALT,  1, 32'h0000_0005, 32'h0000_0003, 1, 32'h0);
    add_case("roli",     1, 3'b001, F7_ROT,  1, PAT, 32'h0000_0001, 1, 32'h0);
    add_case("add f7",   1, 3'b000, 7'h01,   0, 32'h0000_0005, 32'h0000_0003, 1, 32'h0);
    add_case("srl f7",   1, 3'b101, F7_BSET, 0, PAT, 32'h0000_0001, 1, 32'h0);
    add_case("xor f7",   1, 3'b100, F7_ALT,  0, PAT, 32'h0000_0001, 1, 32'h0);
    add_case("and f7",   1, 3'b111, 7'h01,   0, PAT, 32'hFFFF_FFFF, 1, 32'h0);
    add_case("idle ill", 0, 3'b000, F7_ALT,  1, 32'h0000_0005, 32'h0000_0003, 0, 32'h0);

    limit = RESET_CYCLES + cases.size() + N_RAND + MARGIN;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // first check looks at the outputs straight after reset
    exp_name    = "after reset";
    exp_valid   = 1'b0;
    exp_ill     = 1'b0;
    exp_res     = '0;
    last_res    = '0;

    foreach (cases[i])
      apply_op(cases[i].name, cases[i].valid, cases[i].f3, cases[i].f7, cases[i].imm,
               cases[i].a, cases[i].b, cases[i].ill, cases[i].res);

    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift(rng);
      ctl = rng;
      rng = xorshift(rng);
      a   = rng;
      rng = xorshift(rng);
      b   = rng;
      f7  = pick_funct7(ctl[10:8], ctl[17:11]);
      exp = model_op(ctl[2:0], f7, ctl[3], a, b);
      apply_op($sformatf("random %0d", i), ctl[6:4] != 3'd0, ctl[2:0], f7, ctl[3], a, b,
               exp[XLEN], exp[XLEN-1:0]);
    end

    @(posedge clk_i);
    #1;
    check_result();

    $display("%0d tests, %0d passed, %0d failed", n_tests, n_tests - n_fail, n_fail);
    if (n_fail == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hdl/biriq_pkg.sv
hdl/biriq_exec_if.sv
hdl/biriq_decoder.sv
hdl/biriq_alu.sv
hdl/biriq_shifter.sv
hdl/biriq_execute.sv
bench/biriq_execute_props.sv
bench/biriq_execute_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module biriq_execute_tb -f list.f -o sim

./obj_dir/sim +verilator+error+limit+100 | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
